// ==== include/gbt_link_consts.svh ====
`ifndef GBT_LINK_CONSTS_SVH
`define GBT_LINK_CONSTS_SVH

// ----------------------------
// elink frame word layout
// ----------------------------
`define GBT_WORD_W         10     // one elink word per clk40
`define GBT_TTC_W          4      // l1a, calpulse, resync, bc0
`define GBT_PAYLOAD_W      6      // low bits of each word

// ----------------------------
// request fields
// ----------------------------
`define GBT_ADDR_W         16
`define GBT_DATA_W         32

// frame codes
`define GBT_FRAME_START    6'h2A  // first word of every frame
`define GBT_IDLE_PAYLOAD   6'h00  // sent between frames
`define GBT_FRAME_LEN      10     // start, begin, 3 addr, 5 data

// deskew and queue sizing
`define GBT_TAP_W          6      // 64 delay stages
`define GBT_REQ_FIFO_DEPTH 2      // also the requester's starting credits

`endif

// ==== design/gbt_link_pkg.sv ====
package gbt_link_pkg;

  // request opcode, rides in the wr_en bit of the begin word
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } req_op_t;

  // ----------------------------
  // frame slots
  // ----------------------------
  // same encoding on both ends of the link
  typedef enum logic [3:0] {
    SLOT_IDLE  = 4'd0,
    SLOT_START = 4'd1,  // 0x2A marker
    SLOT_BEGIN = 4'd2,  // valid + wr_en
    SLOT_ADDR0 = 4'd3,  // addr[15:10]
    SLOT_ADDR1 = 4'd4,  // addr[9:4]
    SLOT_ADDR2 = 4'd5,  // addr[3:0], data[31:30]
    SLOT_DATA0 = 4'd6,  // data[29:24]
    SLOT_DATA1 = 4'd7,  // data[23:18]
    SLOT_DATA2 = 4'd8,  // data[17:12]
    SLOT_DATA3 = 4'd9,  // data[11:6]
    SLOT_DATA4 = 4'd10  // data[5:0]
  } frame_slot_t;

endpackage

// ==== design/elink_tap_delay.sv ====
`timescale 1ns/100ps

`include "gbt_link_consts.svh"

module elink_tap_delay (
  input  logic                  clk40,
  input  logic                  arst_n_i,
  input  logic [`GBT_TAP_W-1:0] tap_i,
  input  logic                  bit_i,
  output logic                  bit_o
);

  localparam int STAGES = 1 << `GBT_TAP_W;

  // 63 shift flops plus the output flop make 64 stages
  logic [STAGES-2:0]     sr_q;
  logic [STAGES-1:0]     taps;       // tap 0 is the live input
  logic [`GBT_TAP_W-1:0] tap_q;      // previous tap, change detect
  logic [`GBT_TAP_W-1:0] quiet_cnt_q; // cycles since last tap change, saturating

  assign taps = {sr_q, bit_i};

  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sr_q  <= '0;
      bit_o <= 1'b0;
    end else begin
      sr_q  <= taps[STAGES-2:0];
      bit_o <= taps[tap_i];          // tap_i + 1 cycles through
    end
  end

  // ----------------------------
  // tap change monitor
  // ----------------------------
  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tap_q       <= '0;
      quiet_cnt_q <= '1;             // first change after reset is free
    end else begin
      tap_q <= tap_i;
      if (tap_i != tap_q)           quiet_cnt_q <= '0;
      else if (quiet_cnt_q != '1)   quiet_cnt_q <= quiet_cnt_q + 1'b1;
    end
  end

  // line must flush a full 64 cycles between tap moves
  a_tap_quiet: assert property (@(posedge clk40) disable iff (!arst_n_i)
    (tap_i != tap_q) |-> (quiet_cnt_q == '1));

endmodule

// ==== design/req_framer.sv ====
`timescale 1ns/100ps

`include "gbt_link_consts.svh"

module req_framer (
  input  logic                   clk40,
  input  logic                   arst_n_i,
  input  logic                   req_push_i,
  input  gbt_link_pkg::req_op_t  req_op_i,
  input  logic [`GBT_ADDR_W-1:0] req_addr_i,
  input  logic [`GBT_DATA_W-1:0] req_data_i,
  input  logic [`GBT_TTC_W-1:0]  ttc_i,
  output logic                   credit_o,
  output logic [`GBT_WORD_W-1:0] frame_word_o
);
  import gbt_link_pkg::*;

  localparam int PTR_W = $clog2(`GBT_REQ_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`GBT_REQ_FIFO_DEPTH + 1);

  // request queue storage
  req_op_t                op_mem   [`GBT_REQ_FIFO_DEPTH];
  logic [`GBT_ADDR_W-1:0] addr_mem [`GBT_REQ_FIFO_DEPTH];
  logic [`GBT_DATA_W-1:0] data_mem [`GBT_REQ_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             fifo_full;
  logic             fifo_empty;
  logic             push;
  logic             pop;

  // request being framed is held once popped
  req_op_t                cur_op_q;
  logic [`GBT_ADDR_W-1:0] cur_addr_q;
  logic [`GBT_DATA_W-1:0] cur_data_q;

  frame_slot_t               slot_q;
  frame_slot_t               slot_d;
  logic [`GBT_PAYLOAD_W-1:0] payload;

  // ----------------------------
  // credit-controlled FIFO
  // ----------------------------
  assign fifo_full  = (count_q == CNT_W'(`GBT_REQ_FIFO_DEPTH));
  assign fifo_empty = (count_q == '0);
  assign push       = req_push_i && !fifo_full;
  assign pop        = (slot_q == SLOT_START); // head leaves with its start word

  always_ff @(posedge clk40) begin
    if (push) begin
      op_mem[wr_ptr_q]   <= req_op_i;
      addr_mem[wr_ptr_q] <= req_addr_i;
      data_mem[wr_ptr_q] <= req_data_i;
    end
  end

  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      if (pop)  rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      case ({push, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;   // no change on idle or push with pop
      endcase
    end
  end

  // latch head so the FIFO slot frees at start
  always_ff @(posedge clk40) begin
    if (pop) begin
      cur_op_q   <= op_mem[rd_ptr_q];
      cur_addr_q <= addr_mem[rd_ptr_q];
      cur_data_q <= data_mem[rd_ptr_q];
    end
  end

  // ----------------------------
  // slot sequencer
  // ----------------------------
  always_comb begin
    case (slot_q)
      SLOT_IDLE:  slot_d = fifo_empty ? SLOT_IDLE : SLOT_START;
      SLOT_START: slot_d = SLOT_BEGIN;
      SLOT_BEGIN: slot_d = SLOT_ADDR0;
      SLOT_ADDR0: slot_d = SLOT_ADDR1;
      SLOT_ADDR1: slot_d = SLOT_ADDR2;
      SLOT_ADDR2: slot_d = SLOT_DATA0;
      SLOT_DATA0: slot_d = SLOT_DATA1;
      SLOT_DATA1: slot_d = SLOT_DATA2;
      SLOT_DATA2: slot_d = SLOT_DATA3;
      SLOT_DATA3: slot_d = SLOT_DATA4;
      default:    slot_d = SLOT_IDLE;    // data4 always ends in one idle word
    endcase
  end

  // payload mux with msb slices first
  always_comb begin
    case (slot_q)
      SLOT_START: payload = `GBT_FRAME_START;
      SLOT_BEGIN: payload = {1'b1, cur_op_q, {(`GBT_PAYLOAD_W-2){1'b0}}}; // valid and wr_en
      SLOT_ADDR0: payload = cur_addr_q[15:10];
      SLOT_ADDR1: payload = cur_addr_q[9:4];
      SLOT_ADDR2: payload = {cur_addr_q[3:0], cur_data_q[31:30]};
      SLOT_DATA0: payload = cur_data_q[29:24];
      SLOT_DATA1: payload = cur_data_q[23:18];
      SLOT_DATA2: payload = cur_data_q[17:12];
      SLOT_DATA3: payload = cur_data_q[11:6];
      SLOT_DATA4: payload = cur_data_q[5:0];
      default:    payload = `GBT_IDLE_PAYLOAD;
    endcase
  end

  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_q       <= SLOT_IDLE;
      credit_o     <= 1'b0;
      frame_word_o <= {{`GBT_TTC_W{1'b0}}, `GBT_IDLE_PAYLOAD};
    end else begin
      slot_q       <= slot_d;
      credit_o     <= pop;                 // lines up with the start word
      frame_word_o <= {ttc_i, payload};    // ttc on top of every word
    end
  end

  // requester pushed without a credit
  a_push_not_full: assert property (@(posedge clk40) disable iff (!arst_n_i)
    req_push_i |-> !fifo_full);

endmodule

// ==== design/req_deframer.sv ====
`timescale 1ns/100ps

`include "gbt_link_consts.svh"

module req_deframer (
  input  logic                   clk40,
  input  logic                   arst_n_i,
  input  logic [`GBT_WORD_W-1:0] frame_word_i,
  output logic                   req_valid_o,
  output gbt_link_pkg::req_op_t  req_op_o,
  output logic [`GBT_ADDR_W-1:0] req_addr_o,
  output logic [`GBT_DATA_W-1:0] req_data_o,
  output logic [`GBT_TTC_W-1:0]  ttc_o
);
  import gbt_link_pkg::*;

  logic [`GBT_PAYLOAD_W-1:0] payload;
  logic [`GBT_TTC_W-1:0]     ttc_in;
  logic                      begin_valid;  // top payload bit of begin word
  logic                      begin_wr_en;  // next one down
  frame_slot_t               slot_q;       // slot expected for the incoming word
  frame_slot_t               slot_d;
  logic                      valid_d;

  assign payload     = frame_word_i[`GBT_PAYLOAD_W-1:0];
  assign ttc_in      = frame_word_i[`GBT_WORD_W-1:`GBT_PAYLOAD_W];
  assign begin_valid = payload[`GBT_PAYLOAD_W-1];
  assign begin_wr_en = payload[`GBT_PAYLOAD_W-2];

  // ----------------------------
  // frame tracking FSM
  // ----------------------------
  always_comb begin
    valid_d = 1'b0;
    case (slot_q)
      SLOT_IDLE: begin
        // start search only here, never mid frame
        slot_d = (payload == `GBT_FRAME_START) ? SLOT_BEGIN : SLOT_IDLE;
      end
      SLOT_BEGIN: slot_d = begin_valid ? SLOT_ADDR0 : SLOT_IDLE; // drop if not valid
      SLOT_ADDR0: slot_d = SLOT_ADDR1;
      SLOT_ADDR1: slot_d = SLOT_ADDR2;
      SLOT_ADDR2: slot_d = SLOT_DATA0;
      SLOT_DATA0: slot_d = SLOT_DATA1;
      SLOT_DATA1: slot_d = SLOT_DATA2;
      SLOT_DATA2: slot_d = SLOT_DATA3;
      SLOT_DATA3: slot_d = SLOT_DATA4;
      SLOT_DATA4: begin
        slot_d  = SLOT_IDLE;
        valid_d = 1'b1;              // request complete
      end
      default: slot_d = SLOT_IDLE;
    endcase
  end

  always_ff @(posedge clk40 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_q      <= SLOT_IDLE;
      req_valid_o <= 1'b0;
      ttc_o       <= '0;
    end else begin
      slot_q      <= slot_d;
      req_valid_o <= valid_d;        // one cycle after data4
      ttc_o       <= ttc_in;         // follows every word
    end
  end

  // ----------------------------
  // field reassembly
  // ----------------------------
  // addr and data shift in msb first, outputs hold until next frame
  always_ff @(posedge clk40) begin
    case (slot_q)
      SLOT_BEGIN: req_op_o <= req_op_t'(begin_wr_en);
      SLOT_ADDR0,
      SLOT_ADDR1: req_addr_o <= {req_addr_o[`GBT_ADDR_W-7:0], payload};
      SLOT_ADDR2: begin
        req_addr_o <= {req_addr_o[`GBT_ADDR_W-5:0], payload[5:2]};
        req_data_o <= {req_data_o[`GBT_DATA_W-3:0], payload[1:0]}; // data[31:30]
      end
      SLOT_DATA0,
      SLOT_DATA1,
      SLOT_DATA2,
      SLOT_DATA3,
      SLOT_DATA4: req_data_o <= {req_data_o[`GBT_DATA_W-7:0], payload};
      default: ;                     // idle, hold
    endcase
  end

  // frames are at least eleven words apart, so never a double pulse
  a_valid_pulse: assert property (@(posedge clk40) disable iff (!arst_n_i)
    req_valid_o |=> !req_valid_o);

endmodule

// ==== design/gbt_req_link.sv ====
`timescale 1ns/100ps

`include "gbt_link_consts.svh"

module gbt_req_link (
  input  logic                   clk40,
  input  logic                   arst_n_i,
  input  logic [`GBT_TAP_W-1:0]  tap_i,
  input  logic                   req_push_i,
  input  gbt_link_pkg::req_op_t  req_op_i,
  input  logic [`GBT_ADDR_W-1:0] req_addr_i,
  input  logic [`GBT_DATA_W-1:0] req_data_i,
  input  logic [`GBT_TTC_W-1:0]  ttc_i,
  output logic                   credit_o,
  output logic                   req_valid_o,
  output gbt_link_pkg::req_op_t  req_op_o,
  output logic [`GBT_ADDR_W-1:0] req_addr_o,
  output logic [`GBT_DATA_W-1:0] req_data_o,
  output logic [`GBT_TTC_W-1:0]  ttc_o
);

  logic [`GBT_WORD_W-1:0] tx_word;   // framer out
  logic [`GBT_WORD_W-1:0] rx_word;   // after deskew

  // ----------------------------
  // transmit side
  // ----------------------------
  req_framer framer_i (
    .clk40        (clk40),
    .arst_n_i     (arst_n_i),
    .req_push_i   (req_push_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_data_i   (req_data_i),
    .ttc_i        (ttc_i),
    .credit_o     (credit_o),
    .frame_word_o (tx_word)
  );

  // one delay line per bit, common tap keeps the word aligned
  for (genvar i = 0; i < `GBT_WORD_W; i++) begin : g_lane
    elink_tap_delay lane_i (
      .clk40    (clk40),
      .arst_n_i (arst_n_i),
      .tap_i    (tap_i),
      .bit_i    (tx_word[i]),
      .bit_o    (rx_word[i])
    );
  end

  // ----------------------------
  // receive side
  // ----------------------------
  req_deframer deframer_i (
    .clk40        (clk40),
    .arst_n_i     (arst_n_i),
    .frame_word_i (rx_word),
    .req_valid_o  (req_valid_o),
    .req_op_o     (req_op_o),
    .req_addr_o   (req_addr_o),
    .req_data_o   (req_data_o),
    .ttc_o        (ttc_o)
  );

endmodule

// ==== tb/tb_gbt_req_link.sv ====
`timescale 1ns/100ps

`include "gbt_link_consts.svh"

module tb_gbt_req_link;
  import gbt_link_pkg::*;

  localparam int REQ_DEPTH = `GBT_REQ_FIFO_DEPTH;
  localparam int N_REQ     = 19;     // 1 + 4 + 8 + 3 taps x 2
  localparam int TTC_SKIP  = 70;     // line refill after reset or tap move

  typedef struct packed {
    req_op_t                op;
    logic [`GBT_ADDR_W-1:0] addr;
    logic [`GBT_DATA_W-1:0] data;
  } req_t;

  logic                   clk40;
  logic                   arst_n_i;
  logic [`GBT_TAP_W-1:0]  tap_i;
  logic                   req_push_i;
  req_op_t                req_op_i;
  logic [`GBT_ADDR_W-1:0] req_addr_i;
  logic [`GBT_DATA_W-1:0] req_data_i;
  logic [`GBT_TTC_W-1:0]  ttc_i;
  logic                   credit_o;
  logic                   req_valid_o;
  req_op_t                req_op_o;
  logic [`GBT_ADDR_W-1:0] req_addr_o;
  logic [`GBT_DATA_W-1:0] req_data_o;
  logic [`GBT_TTC_W-1:0]  ttc_o;

  logic [15:0]           lfsr_q = 16'h0001;  // seed 1
  req_t                  sent_q[$];          // pushed and not yet seen at the output
  int                    pushes_cnt    = 0;
  int                    credit_pulses = 0;
  int                    cyc           = 0;  // negedges since reset release
  int                    tap_stable    = 0;
  logic [`GBT_TAP_W-1:0] last_tap      = '0;
  logic [`GBT_TTC_W-1:0] hist [256];         // ttc_i per cycle

  gbt_req_link dut_i (.*);

  initial begin
    clk40 = 1'b0;
    forever #10 clk40 = ~clk40;
  end

  // ------------------------------
  // error helpers
  // ------------------------------
  task automatic stop_failed();
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    stop_failed();
  endtask

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    stop_failed();
  endtask

  // ------------------------------
  // stimulus source
  // ------------------------------
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};  // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  function automatic int credits_left();
    return REQ_DEPTH + credit_pulses - pushes_cnt;
  endfunction

  // ------------------------------
  // reference model
  // ------------------------------
  // the link carries a request through unchanged
  function automatic req_t expected_req(input req_t sent);
    return sent;
  endfunction

  // framer reg + tap + 1 lane cycles + deframer reg
  function automatic logic [`GBT_TTC_W-1:0] expected_ttc(input int at_cyc, input int tap);
    return hist[(at_cyc - tap - 3) % 256];
  endfunction

  // ------------------------------
  // drive tasks
  // ------------------------------
  task automatic next_cycle();
    logic [31:0] r;
    @(posedge clk40);
    take_bits(`GBT_TTC_W, r);
    ttc_i      <= r[`GBT_TTC_W-1:0];   // fresh ttc every word
    req_push_i <= 1'b0;
  endtask

  task automatic push_req(input logic rand_op, input req_op_t fixed_op);
    logic [31:0] r;
    req_t        req;
    while (credits_left() == 0) next_cycle();  // hold until a credit returns
    next_cycle();
    take_bits(1, r);
    req.op = rand_op ? req_op_t'(r[0]) : fixed_op;
    take_bits(`GBT_ADDR_W, r);
    req.addr = r[`GBT_ADDR_W-1:0];
    take_bits(`GBT_DATA_W, r);
    req.data = r;
    req_push_i <= 1'b1;                 // overrides the idle drive above
    req_op_i   <= req.op;
    req_addr_i <= req.addr;
    req_data_i <= req.data;
    sent_q.push_back(req);
    pushes_cnt++;
  endtask

  task automatic wait_drain();
    while (sent_q.size() != 0) next_cycle();
    repeat (4) next_cycle();
  endtask

  // line flushed to idles before and after the move
  task automatic change_tap(input logic [`GBT_TAP_W-1:0] t);
    repeat (80) next_cycle();
    next_cycle();
    tap_i <= t;
    repeat (80) next_cycle();
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin : main_seq
    logic [31:0] r;
    logic        end_ok;
    arst_n_i   = 1'b0;
    tap_i      = '0;
    req_push_i = 1'b0;
    req_op_i   = OP_READ;
    req_addr_i = '0;
    req_data_i = '0;
    ttc_i      = '0;
    repeat (5) next_cycle();
    arst_n_i <= 1'b1;
    repeat (80) next_cycle();           // quiet link with nothing coming out
    push_req(1'b0, OP_WRITE);           // single write
    wait_drain();
    repeat (4) push_req(1'b1, OP_READ); // back to back on both credits
    wait_drain();
    for (int i = 0; i < 8; i++) begin   // random op mix with random gaps
      push_req(1'b1, OP_READ);
      take_bits(2, r);
      repeat (r[1:0]) next_cycle();
    end
    wait_drain();
    take_bits(`GBT_TAP_W, r);
    for (int k = 0; k < 3; k++) begin   // tap 0 then 63 then random
      change_tap((k == 0) ? 6'd0 : (k == 1) ? 6'd63 : r[`GBT_TAP_W-1:0]);
      push_req(1'b1, OP_READ);
      push_req(1'b1, OP_READ);
      wait_drain();
    end
    end_ok = 1'b1;
    assert (credit_pulses == pushes_cnt) else begin
      $display("mismatch at %0t: %0d credits back for %0d pushes", $time,
               credit_pulses, pushes_cnt);
      end_ok = 1'b0;
    end
    if (end_ok) begin
      $display("Test OK");
      $finish;
    end else begin
      stop_failed();
    end
  end

  // ------------------------------
  // per-cycle monitor
  // ------------------------------
  always @(negedge clk40) begin : monitor
    logic [`GBT_TTC_W-1:0] exp_ttc;
    if (arst_n_i) begin
      hist[cyc % 256] = ttc_i;
      if (tap_i != last_tap) tap_stable = 0;
      else if (tap_stable < 1000) tap_stable++;
      last_tap = tap_i;
      if (credit_o) begin
        credit_pulses++;
        // each credit pairs with one earlier push
        assert (credit_pulses <= pushes_cnt)
          else report_error("credit returned for a request that was never pushed");
      end
      if (pushes_cnt == 0) begin
        assert (!req_valid_o && !credit_o)
          else report_error("output active before any request was pushed");
      end
      if (cyc >= TTC_SKIP && tap_stable >= TTC_SKIP) begin
        exp_ttc = expected_ttc(cyc, tap_i);
        assert (ttc_o == exp_ttc) else report_mismatch("ttc_o", 32'(ttc_o), 32'(exp_ttc));
      end
      cyc++;
    end
  end

  // head of queue against each valid pulse
  always @(negedge clk40) begin : compare
    req_t exp;
    if (arst_n_i && req_valid_o) begin
      if (sent_q.size() == 0) begin
        report_error("a request came out that was never sent");
      end else begin
        exp = expected_req(sent_q.pop_front());
        assert (req_op_o == exp.op) else report_mismatch("op", 32'(req_op_o), 32'(exp.op));
        assert (req_addr_o == exp.addr)
          else report_mismatch("addr", 32'(req_addr_o), 32'(exp.addr));
        assert (req_data_o == exp.data) else report_mismatch("data", req_data_o, exp.data);
      end
    end
  end

  initial begin : watchdog
    repeat (N_REQ * 40 + 1000) @(posedge clk40);
    $display("timeout: the run did not finish, %0d requests still outstanding",
             sent_q.size());
    stop_failed();
  end

endmodule

// ==== files.f ====
+incdir+include
design/gbt_link_pkg.sv
design/elink_tap_delay.sv
design/req_framer.sv
design/req_deframer.sv
design/gbt_req_link.sv
tb/tb_gbt_req_link.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module tb_gbt_req_link -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
